// File: mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte address width on the fetch bus and the data bus
`define MEM_ADDR_W 32

// word index bits, the RAM holds 2**MEM_WORD_AW words
// index comes from address bits [MEM_WORD_AW+1:2]
`define MEM_WORD_AW 13

// entries in the fetch skid buffer
`define FETCH_BUF_DEPTH 2

`endif

// File: mem_pkg.sv
package mem_pkg;

  // load/store opcodes
  typedef enum logic [2:0] {
    LSU_LB  = 3'd0,
    LSU_LH  = 3'd1,
    LSU_LW  = 3'd2,
    LSU_LBU = 3'd3,
    LSU_LHU = 3'd4,
    LSU_SB  = 3'd5,
    LSU_SH  = 3'd6,
    LSU_SW  = 3'd7
  } lsu_op_e;

  // fetch skid buffer occupancy
  typedef enum logic [1:0] {
    FB_EMPTY = 2'd0,
    FB_ONE   = 2'd1,
    FB_TWO   = 2'd2
  } fbuf_state_e;

endpackage

// File: wb_if.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

// pipelined instruction fetch bus, read only
interface wb_if;

  logic                   cyc;
  logic                   stb;
  logic [`MEM_ADDR_W-1:0] adr;
  logic [3:0]             sel;
  logic                   ack;
  logic [31:0]            dat_r;

  modport master (
    output cyc,
    output stb,
    output adr,
    output sel,
    input  ack,
    input  dat_r
  );

  modport slave (
    input  cyc,
    input  stb,
    input  adr,
    input  sel,
    output ack,
    output dat_r
  );

endinterface

// File: membus_if.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

// data memory bus for loads and stores
interface membus_if;

  logic                   req;
  logic                   write;
  logic [`MEM_ADDR_W-1:0] addr;
  logic [31:0]            wdata;
  logic [3:0]             wr_mask;
  logic                   ack;
  logic [31:0]            rdata;

  modport requester (
    output req,
    output write,
    output addr,
    output wdata,
    output wr_mask,
    input  ack,
    input  rdata
  );

  modport memory (
    input  req,
    input  write,
    input  addr,
    input  wdata,
    input  wr_mask,
    output ack,
    output rdata
  );

endinterface

// File: byte_lane_ram.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module byte_lane_ram (
  input  logic     clk,
  wb_if.slave      wb,
  membus_if.memory dbus,
  input  logic     rst_i
);

  localparam int DEPTH = 2 ** `MEM_WORD_AW;

  logic                    fetch_req;
  logic [`MEM_WORD_AW-1:0] fetch_idx;
  logic [`MEM_WORD_AW-1:0] data_idx;
  logic [7:0]              fetch_byte_q [4];
  logic [7:0]              data_byte_q [4];

  assign fetch_req = wb.cyc && wb.stb;

  // word index ignores the bits above the array size
  assign fetch_idx = wb.adr[`MEM_WORD_AW+1:2];
  assign data_idx  = dbus.addr[`MEM_WORD_AW+1:2];

  for (genvar g = 0; g < 4; g++)
  begin : g_lane
    logic [7:0] lane_mem [DEPTH];

    // fetch port reads lanes outside sel as zero
    always_ff @(posedge clk)
    begin
      if (fetch_req)
      begin
        fetch_byte_q[g] <= {8{wb.sel[g]}} & lane_mem[fetch_idx];
      end
    end

    // data port returns the old byte even on a write
    always_ff @(posedge clk)
    begin
      if (dbus.req)
      begin
        if (dbus.write && dbus.wr_mask[g])
        begin
          lane_mem[data_idx] <= dbus.wdata[8*g +: 8];
        end
        data_byte_q[g] <= lane_mem[data_idx];
      end
    end
  end

  assign wb.dat_r   = {fetch_byte_q[3], fetch_byte_q[2], fetch_byte_q[1], fetch_byte_q[0]};
  assign dbus.rdata = {data_byte_q[3], data_byte_q[2], data_byte_q[1], data_byte_q[0]};

  // both ports always accept and ack one cycle later
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      wb.ack   <= 1'b0;
      dbus.ack <= 1'b0;
    end
    else
    begin
      wb.ack   <= fetch_req;
      dbus.ack <= dbus.req;
    end
  end

  // fetch master has to enable at least one lane
  a_sel_nonzero: assert property (
    @(posedge clk) disable iff (rst_i)
    fetch_req |-> (wb.sel != 4'h0)
  );

endmodule

// File: instr_fetch.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module instr_fetch (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   fetch_en_i,
  input  logic                   redirect_i,
  input  logic [`MEM_ADDR_W-1:0] redirect_pc_i,
  input  logic                   instr_ready_i,
  output logic                   instr_valid_o,
  output logic [31:0]            instr_o,
  output logic [`MEM_ADDR_W-1:0] instr_pc_o,
  wb_if.master                   wb
);

  import mem_pkg::*;

  logic [`MEM_ADDR_W-1:0] pc_q;
  logic [`MEM_ADDR_W-1:0] pend_pc_q;
  logic                   pend_q;
  logic                   pend_drop_q;

  fbuf_state_e            fb_state_q;
  fbuf_state_e            fb_state_d;
  logic [31:0]            buf_instr_q [`FETCH_BUF_DEPTH];
  logic [`MEM_ADDR_W-1:0] buf_pc_q [`FETCH_BUF_DEPTH];

  logic       head_valid;
  logic       push;
  logic       pop;
  logic       issue;
  logic       wait_rsp;
  logic       wr_sel;
  logic [1:0] fill_cur;
  logic [1:0] fill_nxt;

  assign head_valid = (fb_state_q != FB_EMPTY);

  // nothing is handed out in a redirect cycle
  assign instr_valid_o = head_valid && !redirect_i;
  assign instr_o       = buf_instr_q[0];
  assign instr_pc_o    = buf_pc_q[0];

  assign pop  = instr_valid_o && instr_ready_i;
  assign push = wb.ack && pend_q && !pend_drop_q && !redirect_i;

  // request still in flight without its response this cycle
  assign wait_rsp = pend_q && !wb.ack;

  always_comb
  begin
    case (fb_state_q)
      FB_ONE:  fill_cur = 2'd1;
      FB_TWO:  fill_cur = 2'd2;
      default: fill_cur = 2'd0;
    endcase
    fill_nxt = fill_cur + 2'(push) - 2'(pop);
    case (fill_nxt)
      2'd0:    fb_state_d = FB_EMPTY;
      2'd1:    fb_state_d = FB_ONE;
      default: fb_state_d = FB_TWO;
    endcase
  end

  // new request only if its response is sure to find a free slot
  assign issue = fetch_en_i && !redirect_i && !wait_rsp &&
                 (fill_nxt < 2'(`FETCH_BUF_DEPTH));

  assign wb.cyc = issue || pend_q;
  assign wb.stb = issue;
  assign wb.adr = pc_q;
  assign wb.sel = 4'hF;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      pc_q        <= '0;
      pend_q      <= 1'b0;
      pend_drop_q <= 1'b0;
    end
    else if (redirect_i)
    begin
      pc_q        <= {redirect_pc_i[`MEM_ADDR_W-1:2], 2'b00};
      // a response still to come belongs to the old stream
      pend_q      <= wait_rsp;
      pend_drop_q <= wait_rsp;
    end
    else if (issue)
    begin
      pc_q        <= pc_q + `MEM_ADDR_W'd4;
      pend_q      <= 1'b1;
      pend_drop_q <= 1'b0;
    end
    else if (wb.ack)
    begin
      pend_q      <= 1'b0;
      pend_drop_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      pend_pc_q <= pc_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst_i || redirect_i)
    begin
      fb_state_q <= FB_EMPTY;
    end
    else
    begin
      fb_state_q <= fb_state_d;
    end
  end

  // slot for the incoming word after the head moves on
  assign wr_sel = (fb_state_q == FB_TWO) || ((fb_state_q == FB_ONE) && !pop);

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      buf_instr_q[0] <= buf_instr_q[1];
      buf_pc_q[0]    <= buf_pc_q[1];
    end
    if (push)
    begin
      buf_instr_q[wr_sel] <= wb.dat_r;
      buf_pc_q[wr_sel]    <= pend_pc_q;
    end
  end

  // issue rule has to keep a full buffer from taking another word
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst_i)
    ((fb_state_q == FB_TWO) && !pop) |-> !push
  );

  a_stall_stable: assert property (
    @(posedge clk) disable iff (rst_i)
    (instr_valid_o && !instr_ready_i) |=>
      (redirect_i || (instr_valid_o && $stable(instr_o) && $stable(instr_pc_o)))
  );

endmodule

// File: load_store_unit.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module load_store_unit (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   lsu_valid_i,
  input  mem_pkg::lsu_op_e       lsu_op_i,
  input  logic [`MEM_ADDR_W-1:0] lsu_addr_i,
  input  logic [31:0]            lsu_wdata_i,
  output logic                   lsu_done_o,
  output logic [31:0]            lsu_rdata_o,
  output logic                   lsu_misaligned_o,
  membus_if.requester            dbus
);

  import mem_pkg::*;

  logic [1:0]  offs;
  logic        misaligned;
  logic        is_store;
  logic [3:0]  mask;
  logic [31:0] lane_data;

  lsu_op_e     op_q;
  logic [1:0]  offs_q;
  logic        done_q;
  logic        misal_q;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  assign offs = lsu_addr_i[1:0];

  always_comb
  begin
    misaligned = 1'b0;
    is_store   = 1'b0;
    mask       = 4'h0;
    lane_data  = lsu_wdata_i;
    case (lsu_op_i)
      LSU_LH, LSU_LHU: misaligned = offs[0];
      LSU_LW:          misaligned = (offs != 2'b00);
      LSU_SB:
      begin
        is_store  = 1'b1;
        mask      = 4'b0001 << offs;
        lane_data = {4{lsu_wdata_i[7:0]}};
      end
      LSU_SH:
      begin
        is_store   = 1'b1;
        misaligned = offs[0];
        mask       = 4'b0011 << offs;
        lane_data  = {2{lsu_wdata_i[15:0]}};
      end
      LSU_SW:
      begin
        is_store   = 1'b1;
        misaligned = (offs != 2'b00);
        mask       = 4'hF;
      end
      default: misaligned = 1'b0;
    endcase
  end

  // misaligned requests never reach the bus
  assign dbus.req     = lsu_valid_i && !misaligned;
  assign dbus.write   = is_store;
  assign dbus.addr    = lsu_addr_i;
  assign dbus.wdata   = lane_data;
  assign dbus.wr_mask = mask;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      done_q  <= 1'b0;
      misal_q <= 1'b0;
    end
    else
    begin
      done_q  <= lsu_valid_i;
      misal_q <= lsu_valid_i && misaligned;
    end
  end

  always_ff @(posedge clk)
  begin
    if (lsu_valid_i)
    begin
      op_q   <= lsu_op_i;
      offs_q <= offs;
    end
  end

  // pick the addressed lanes from the returned word
  assign rd_byte = dbus.rdata[8*offs_q +: 8];
  assign rd_half = offs_q[1] ? dbus.rdata[31:16] : dbus.rdata[15:0];

  always_comb
  begin
    lsu_rdata_o = '0;
    if (!misal_q)
    begin
      case (op_q)
        LSU_LB:  lsu_rdata_o = {{24{rd_byte[7]}}, rd_byte};
        LSU_LBU: lsu_rdata_o = {24'h0, rd_byte};
        LSU_LH:  lsu_rdata_o = {{16{rd_half[15]}}, rd_half};
        LSU_LHU: lsu_rdata_o = {16'h0, rd_half};
        LSU_LW:  lsu_rdata_o = dbus.rdata;
        default: lsu_rdata_o = '0;
      endcase
    end
  end

  assign lsu_done_o       = done_q;
  assign lsu_misaligned_o = misal_q;

  // completion relies on the memory answering in exactly one cycle
  a_done_has_ack: assert property (
    @(posedge clk) disable iff (rst_i)
    (lsu_done_o && !lsu_misaligned_o) |-> dbus.ack
  );

  a_ack_after_req: assert property (
    @(posedge clk) disable iff (rst_i)
    dbus.ack |-> $past(dbus.req)
  );

endmodule

// File: soc_mem_top.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module soc_mem_top (
  input  logic                   clk,
  input  logic                   rst_i,

  // instruction fetch side
  input  logic                   fetch_en_i,
  input  logic                   redirect_i,
  input  logic [`MEM_ADDR_W-1:0] redirect_pc_i,
  input  logic                   instr_ready_i,
  output logic                   instr_valid_o,
  output logic [31:0]            instr_o,
  output logic [`MEM_ADDR_W-1:0] instr_pc_o,

  // load/store side
  input  logic                   lsu_valid_i,
  input  mem_pkg::lsu_op_e       lsu_op_i,
  input  logic [`MEM_ADDR_W-1:0] lsu_addr_i,
  input  logic [31:0]            lsu_wdata_i,
  output logic                   lsu_done_o,
  output logic [31:0]            lsu_rdata_o,
  output logic                   lsu_misaligned_o
);

  wb_if     wb_bus ();
  membus_if dbus ();

  instr_fetch u_fetch (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_en_i    (fetch_en_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .wb            (wb_bus.master)
  );

  load_store_unit u_lsu (
    .clk              (clk),
    .rst_i            (rst_i),
    .lsu_valid_i      (lsu_valid_i),
    .lsu_op_i         (lsu_op_i),
    .lsu_addr_i       (lsu_addr_i),
    .lsu_wdata_i      (lsu_wdata_i),
    .lsu_done_o       (lsu_done_o),
    .lsu_rdata_o      (lsu_rdata_o),
    .lsu_misaligned_o (lsu_misaligned_o),
    .dbus             (dbus.requester)
  );

  // each agent owns one RAM port
  byte_lane_ram u_ram (
    .clk   (clk),
    .wb    (wb_bus.slave),
    .dbus  (dbus.memory),
    .rst_i (rst_i)
  );

endmodule

// File: tb_soc_mem.sv
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_soc_mem;

  import mem_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int N_LSU_OPS    = 400;
  localparam int N_FETCH      = 600;
  localparam int WINDOW_WORDS = 256;
  localparam int N_REDIRECTS  = 10;
  localparam int REDIRECT_RUN = 38;
  localparam int WATCHDOG_NS  = (N_LSU_OPS + N_FETCH) * 4 * CLK_PERIOD;

  logic                   clk;
  logic                   rst_i;
  logic                   fetch_en_i;
  logic                   redirect_i;
  logic [`MEM_ADDR_W-1:0] redirect_pc_i;
  logic                   instr_ready_i;
  logic                   instr_valid_o;
  logic [31:0]            instr_o;
  logic [`MEM_ADDR_W-1:0] instr_pc_o;
  logic                   lsu_valid_i;
  lsu_op_e                lsu_op_i;
  logic [`MEM_ADDR_W-1:0] lsu_addr_i;
  logic [31:0]            lsu_wdata_i;
  logic                   lsu_done_o;
  logic [31:0]            lsu_rdata_o;
  logic                   lsu_misaligned_o;

  // reference copy of the RAM contents
  logic [31:0]            model [2 ** `MEM_WORD_AW];
  logic [`MEM_ADDR_W-1:0] exp_pc;
  int                     lsu_errors;
  int                     fetch_errors;
  int                     lsu_checks;
  int                     fetch_checks;
  bit                     fetch_phase;
  int                     occ_empty;
  int                     occ_one;
  int                     occ_two;

  soc_mem_top i_dut (
    .clk              (clk),
    .rst_i            (rst_i),
    .fetch_en_i       (fetch_en_i),
    .redirect_i       (redirect_i),
    .redirect_pc_i    (redirect_pc_i),
    .instr_ready_i    (instr_ready_i),
    .instr_valid_o    (instr_valid_o),
    .instr_o          (instr_o),
    .instr_pc_o       (instr_pc_o),
    .lsu_valid_i      (lsu_valid_i),
    .lsu_op_i         (lsu_op_i),
    .lsu_addr_i       (lsu_addr_i),
    .lsu_wdata_i      (lsu_wdata_i),
    .lsu_done_o       (lsu_done_o),
    .lsu_rdata_o      (lsu_rdata_o),
    .lsu_misaligned_o (lsu_misaligned_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // initial contents of the test window, mixes all address bits
  function automatic logic [31:0] fill_word(input logic [`MEM_ADDR_W-1:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  function automatic logic [`MEM_WORD_AW-1:0] word_idx(input logic [`MEM_ADDR_W-1:0] addr);
    return addr[`MEM_WORD_AW+1:2];
  endfunction

  function automatic bit is_misaligned(input lsu_op_e op, input logic [1:0] offs);
    case (op)
      LSU_LH, LSU_LHU, LSU_SH: return offs[0];
      LSU_LW, LSU_SW:          return (offs != 2'b00);
      default:                 return 1'b0;
    endcase
  endfunction

  // expected load result after lane select and extension
  function automatic logic [31:0] load_value(input lsu_op_e op, input logic [31:0] word,
                                             input logic [1:0] offs);
    logic [31:0] shifted;
    shifted = word >> (8 * offs);
    case (op)
      LSU_LB:  return {{24{shifted[7]}}, shifted[7:0]};
      LSU_LBU: return {24'h0, shifted[7:0]};
      LSU_LH:  return {{16{shifted[15]}}, shifted[15:0]};
      LSU_LHU: return {16'h0, shifted[15:0]};
      default: return word;
    endcase
  endfunction

  task automatic store_model(input lsu_op_e op, input logic [`MEM_ADDR_W-1:0] addr,
                             input logic [31:0] wdata);
    logic [`MEM_WORD_AW-1:0] idx;
    logic [31:0]             word;
    logic [1:0]              offs;
    idx  = word_idx(addr);
    word = model[idx];
    offs = addr[1:0];
    case (op)
      LSU_SB:  word[8*offs +: 8] = wdata[7:0];
      LSU_SH:  word[8*offs +: 16] = wdata[15:0];
      LSU_SW:  word = wdata;
      default: word = model[idx];
    endcase
    model[idx] = word;
  endtask

  // called a little after a rising edge, returns one cycle later
  task automatic lsu_op(input lsu_op_e op, input logic [`MEM_ADDR_W-1:0] addr,
                        input logic [31:0] wdata);
    bit          exp_misal;
    bit          is_load;
    logic [31:0] exp_data;
    exp_misal = is_misaligned(op, addr[1:0]);
    is_load   = (op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU});
    exp_data  = load_value(op, model[word_idx(addr)], addr[1:0]);
    if (!is_load && !exp_misal)
    begin
      store_model(op, addr, wdata);
    end
    lsu_valid_i = 1'b1;
    lsu_op_i    = op;
    lsu_addr_i  = addr;
    lsu_wdata_i = wdata;
    @(posedge clk);
    #1;
    lsu_valid_i = 1'b0;
    lsu_checks++;
    assert (lsu_done_o == 1'b1)
    else
    begin
      $display("MISMATCH at %0t: %s 0x%08h done expected 1 actual %0b",
               $time, op.name(), addr, lsu_done_o);
      lsu_errors++;
    end
    assert (lsu_misaligned_o == exp_misal)
    else
    begin
      $display("MISMATCH at %0t: %s 0x%08h misaligned expected %0b actual %0b",
               $time, op.name(), addr, exp_misal, lsu_misaligned_o);
      lsu_errors++;
    end
    if (is_load && !exp_misal)
    begin
      assert (lsu_rdata_o == exp_data)
      else
      begin
        $display("MISMATCH at %0t: %s 0x%08h rdata expected 0x%08h actual 0x%08h",
                 $time, op.name(), addr, exp_data, lsu_rdata_o);
        lsu_errors++;
      end
    end
  endtask

  // accept n instructions, sampled mid-cycle once inputs have settled
  task automatic accept_instrs(input int n, input bit random_ready);
    int got;
    got = 0;
    while (got < n)
    begin
      @(posedge clk);
      #1;
      redirect_i    = 1'b0;
      instr_ready_i = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      #4;
      if (instr_valid_o && instr_ready_i)
      begin
        fetch_checks++;
        assert (instr_pc_o == exp_pc)
        else
        begin
          $display("MISMATCH at %0t: fetch pc expected 0x%08h actual 0x%08h",
                   $time, exp_pc, instr_pc_o);
          fetch_errors++;
        end
        assert (instr_o == model[word_idx(exp_pc)])
        else
        begin
          $display("MISMATCH at %0t: instr at 0x%08h expected 0x%08h actual 0x%08h",
                   $time, exp_pc, model[word_idx(exp_pc)], instr_o);
          fetch_errors++;
        end
        exp_pc = exp_pc + 32'd4;
        got++;
      end
    end
  endtask

  task automatic redirect_to(input logic [`MEM_ADDR_W-1:0] target);
    @(posedge clk);
    #1;
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    instr_ready_i = 1'b1;
    #4;
    assert (!instr_valid_o)
    else
    begin
      $display("error at %0t: an instruction was offered in a redirect cycle", $time);
      fetch_errors++;
    end
    exp_pc = target & ~32'h3;
  endtask

  // buffer occupancy, only for the summary
  always @(negedge clk)
  begin
    if (fetch_phase)
    begin
      case (i_dut.u_fetch.fb_state_q)
        FB_EMPTY: occ_empty++;
        FB_ONE:   occ_one++;
        FB_TWO:   occ_two++;
        default:  occ_empty = occ_empty;
      endcase
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    lsu_op_e                op;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [31:0]            wdata;
    logic [`MEM_ADDR_W-1:0] word;
    void'($urandom(32'h3df32672));
    rst_i         = 1'b1;
    fetch_en_i    = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    instr_ready_i = 1'b0;
    lsu_valid_i   = 1'b0;
    lsu_op_i      = LSU_LW;
    lsu_addr_i    = '0;
    lsu_wdata_i   = '0;
    exp_pc        = '0;
    fetch_phase   = 1'b0;
    for (int i = 0; i < 2 ** `MEM_WORD_AW; i++)
    begin
      model[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_i = 1'b0;
    assert (!lsu_done_o && !instr_valid_o)
    else
    begin
      $display("error at %0t: outputs not idle after reset", $time);
      lsu_errors++;
    end

    // fill the window through the store path, back to back
    for (int i = 0; i < WINDOW_WORDS; i++)
    begin
      lsu_op(LSU_SW, 32'(i) << 2, fill_word(32'(i) << 2));
    end

    for (int i = 0; i < N_LSU_OPS; i++)
    begin
      op    = lsu_op_e'(3'($urandom_range(0, 7)));
      addr  = 32'($urandom_range(0, WINDOW_WORDS - 1)) << 2;
      addr  = addr | 32'($urandom_range(0, 3));
      wdata = $urandom();
      lsu_op(op, addr, wdata);
    end

    // fetch from pc 0, first without then with back-pressure
    fetch_phase = 1'b1;
    fetch_en_i  = 1'b1;
    accept_instrs(100, 1'b0);
    accept_instrs(N_FETCH - 100 - N_REDIRECTS * REDIRECT_RUN, 1'b1);
    for (int r = 0; r < N_REDIRECTS; r++)
    begin
      word = 32'($urandom_range(0, WINDOW_WORDS - REDIRECT_RUN - 2));
      addr = (word << 2) | 32'($urandom_range(0, 3));
      redirect_to(addr);
      accept_instrs(REDIRECT_RUN, 1'b1);
    end
    fetch_phase = 1'b0;

    $display("fetch buffer cycles empty %0d one %0d two %0d", occ_empty, occ_one, occ_two);
    $display("checks lsu %0d fetch %0d, errors lsu %0d fetch %0d total %0d",
             lsu_checks, fetch_checks, lsu_errors, fetch_errors, lsu_errors + fetch_errors);
    if (lsu_errors + fetch_errors == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+.
mem_pkg.sv
wb_if.sv
membus_if.sv
byte_lane_ram.sv
instr_fetch.sv
load_store_unit.sv
soc_mem_top.sv
tb_soc_mem.sv

// File: Makefile
TOP = tb_soc_mem
OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 -f filelist.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)
	@out=$$(./$(OBJ)/$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ)
